// File: dv/phy_selftest_tb.sv
/* Loopback testbench for the PHY self-test. Frame starts are taken from the generator's
   start accept and words inside a frame follow tx_rd. Checks are assertions */
`timescale 1ns/10ps

module phy_selftest_tb;
   import selftest_pkt_pkg::*;
   import selftest_ctl_pkg::*;

   localparam int FINISH_TIMEOUT = 20000;

   logic          clk;
   logic          reset;
   logic          start;
   selftest_cfg_t cfg;
   logic          tx_rd    = 1'b0;
   frame_word_t   tx_word;
   logic          rx_valid = 1'b0;
   frame_word_t   rx_word  = '0;
   logic          running;
   logic          finished;
   result_t       result;

   integer seed = 7745;
   int     value_errors = 0;
   int     timeouts = 0;
   logic   started = 1'b0;
   // Totals expected from the current run
   int     exp_total = 0;
   int     exp_bad = 0;
   int     flip_frame = -1;

   // Transmit side tracking of the word now on tx_word
   logic   tx_accept;
   logic   word_new = 1'b0;
   // Reads taken in the open frame, zero between frames
   int     rd_cnt = 0;
   int     tx_idx = 0;
   int     tx_frame = 0;
   word_t  tx_rand = '0;
   pattern_t tx_pat;
   seq_t   tx_seq;
   int     tx_words;
   logic   tx_is_last;
   word_t  tx_exp_data;
   ctrl_t  tx_exp_ctrl;

   // Loopback delay line
   frame_word_t rx_q[$];
   int          rel_q[$];
   frame_word_t lb_word;
   int          lb_idx = 0;
   int          lb_frame = 0;
   int          cycle = 0;
   int          release_at;
   int          last_release = 0;

   tb_clk_gen i_tb_clk_gen (.clk(clk), .reset(reset));

   phy_selftest i_phy_selftest (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .cfg      (cfg),
      .tx_rd    (tx_rd),
      .tx_word  (tx_word),
      .rx_valid (rx_valid),
      .rx_word  (rx_word),
      .running  (running),
      .finished (finished),
      .result   (result)
   );

   // Frame start taken from the generator and later reads from tx_rd alone
   assign tx_accept = i_phy_selftest.i_phy_test_pktgen.start_frame |
                      (tx_rd && rd_cnt != 0);

   // ==============================
   // Frame format model
   // ==============================
   // Patterns run lowest enable bit first with count frames each
   function automatic pattern_t frame_pattern(pattern_t en, int frame, int count);
      int       n;
      pattern_t p;
      n = (count == 0) ? 0 : frame / count;
      p = '0;
      for (int b = 0; b < 5; b++) begin
         if (en[b]) begin
            if (n == 0)
               p = pattern_t'(1 << b);
            n = n - 1;
         end
      end
      return p;
   endfunction

   // Galois step of x^32 + x^22 + x^2 + x + 1
   function automatic word_t lfsr_next(word_t v);
      word_t taps;
      taps = 32'h0040_0007;
      return v[31] ? ({v[30:0], 1'b0} ^ taps) : {v[30:0], 1'b0};
   endfunction

   function automatic ctrl_t end_marker(pkt_size_t size);
      case (size[1:0])
         2'd0:    return 4'b0001;
         2'd1:    return 4'b1000;
         2'd2:    return 4'b0100;
         default: return 4'b0010;
      endcase
   endfunction

   function automatic word_t expected_data(int idx, pattern_t pat, seq_t seq, word_t rnd,
                                           port_t port, pkt_size_t size);
      word_t w;
      if (idx == 0)
         w = 32'h00ca_fe00;
      else if (idx == 1)
         w = {8'h01, 5'd0, port, 16'h00ca};
      else if (idx == 2)
         w = {24'hfe_0000, 5'd0, port};
      else if (idx == 3)
         w = {4'hf, 1'b0, size, 8'h00, 3'd0, pat};
      else if (idx == 4)
         w = seq;
      else if (pat == PAT_ALL_1)
         w = 32'hffff_ffff;
      else if (pat == PAT_ALT_01)
         w = 32'h5555_5555;
      else if (pat == PAT_ALT_10)
         w = 32'haaaa_aaaa;
      else if (pat == PAT_RANDOM)
         w = rnd;
      else
         w = 32'h0000_0000;
      return w;
   endfunction

   always_comb begin
      tx_pat      = frame_pattern(cfg.pattern_en, tx_frame, int'(cfg.pkt_count));
      tx_seq      = cfg.seed + seq_t'(tx_frame);
      tx_words    = (int'(cfg.pkt_size) + 3) / 4;
      tx_is_last  = tx_idx == tx_words - 1;
      tx_exp_data = expected_data(tx_idx, tx_pat, tx_seq, tx_rand, cfg.port, cfg.pkt_size);
      tx_exp_ctrl = tx_is_last ? end_marker(cfg.pkt_size) : '0;
   end

   // Word index, frame index and expected random word follow the checked word
   always @(posedge clk) begin
      word_new <= tx_accept && !reset;
      if (reset || !running)
         rd_cnt <= 0;
      else if (i_phy_selftest.i_phy_test_pktgen.start_frame)
         rd_cnt <= 1;
      else if (tx_rd && rd_cnt != 0)
         rd_cnt <= (rd_cnt == tx_words - 1) ? 0 : rd_cnt + 1;
      if (!running) begin
         tx_idx   <= 0;
         tx_frame <= 0;
      end else if (word_new) begin
         if (tx_idx == 4)
            tx_rand <= tx_seq;
         else if (tx_idx >= 5)
            tx_rand <= lfsr_next(tx_rand);
         if (tx_is_last) begin
            tx_idx   <= 0;
            tx_frame <= tx_frame + 1;
         end else begin
            tx_idx <= tx_idx + 1;
         end
      end
   end

   // ==============================
   // Loopback and read strobe
   // ==============================
   always @(negedge clk) begin
      cycle = cycle + 1;
      // Roughly one read in four is skipped
      tx_rd = ($random(seed) & 3) != 0;
      if (!running) begin
         lb_idx   = 0;
         lb_frame = 0;
      end
      if (word_new) begin
         lb_word = tx_word;
         // Corrupt the second payload word of one chosen frame
         if (lb_frame == flip_frame && lb_idx == 6)
            lb_word.data[3] = ~lb_word.data[3];
         release_at = cycle + 1 + ($random(seed) & 3);
         if (release_at <= last_release)
            release_at = last_release + 1;
         last_release = release_at;
         rx_q.push_back(lb_word);
         rel_q.push_back(release_at);
         if (tx_word.last) begin
            lb_idx   = 0;
            lb_frame = lb_frame + 1;
         end else begin
            lb_idx = lb_idx + 1;
         end
      end
      if (rx_q.size() > 0 && rel_q[0] <= cycle) begin
         rx_valid = 1'b1;
         rx_word  = rx_q.pop_front();
         void'(rel_q.pop_front());
      end else begin
         rx_valid = 1'b0;
         rx_word  = '0;
      end
   end

   // ==============================
   // Assertions
   // ==============================
   assert property (@(posedge clk) disable iff (reset) word_new |-> tx_word.data == tx_exp_data)
      else begin
         value_errors++;
         $display("Error tx_word.data word %0d frame %0d: expected %h, got %h",
                  $sampled(tx_idx), $sampled(tx_frame), $sampled(tx_exp_data),
                  $sampled(tx_word.data));
      end

   assert property (@(posedge clk) disable iff (reset) word_new |-> tx_word.ctrl == tx_exp_ctrl)
      else begin
         value_errors++;
         $display("Error tx_word.ctrl word %0d: expected %h, got %h",
                  $sampled(tx_idx), $sampled(tx_exp_ctrl), $sampled(tx_word.ctrl));
      end

   assert property (@(posedge clk) disable iff (reset) word_new |-> tx_word.last == tx_is_last)
      else begin
         value_errors++;
         $display("Error tx_word.last word %0d: expected %h, got %h",
                  $sampled(tx_idx), $sampled(tx_is_last), $sampled(tx_word.last));
      end

   // Quiet outputs from reset until the first start
   assert property (@(posedge clk) disable iff (reset)
      !started |-> (!running && !finished && result == '0 && tx_word.ctrl == '0))
      else begin
         value_errors++;
         $display("Error before start: running %h, finished %h, result %h, tx_word.ctrl %h",
                  $sampled(running), $sampled(finished), $sampled(result),
                  $sampled(tx_word.ctrl));
      end

   assert property (@(posedge clk) disable iff (reset)
      finished |-> result.sent == pkt_count_t'(exp_total))
      else begin
         value_errors++;
         $display("Error result.sent: expected %h, got %h",
                  $sampled(exp_total), $sampled(result.sent));
      end

   assert property (@(posedge clk) disable iff (reset)
      finished |-> result.good == pkt_count_t'(exp_total - exp_bad))
      else begin
         value_errors++;
         $display("Error result.good: expected %h, got %h",
                  $sampled(exp_total - exp_bad), $sampled(result.good));
      end

   assert property (@(posedge clk) disable iff (reset)
      finished |-> result.bad == pkt_count_t'(exp_bad))
      else begin
         value_errors++;
         $display("Error result.bad: expected %h, got %h",
                  $sampled(exp_bad), $sampled(result.bad));
      end

   // ==============================
   // Stimulus
   // ==============================
   task automatic wait_reset_done();
      int n;
      n = 0;
      @(negedge clk);
      while (reset && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (reset) begin
         timeouts++;
         $display("Timeout: reset was never released");
      end
   endtask

   task automatic wait_finished();
      int n;
      n = 0;
      while (!finished && n < FINISH_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!finished) begin
         timeouts++;
         $display("Timeout: run did not finish within %0d cycles", FINISH_TIMEOUT);
      end
   endtask

   // One run with flip naming the frame that gets a corrupted payload bit or -1 for none
   task automatic run_test(pattern_t en, pkt_size_t size, int count, seq_t first_seq,
                           int flip);
      if (timeouts == 0) begin
         @(negedge clk);
         cfg.pattern_en = en;
         cfg.pkt_size   = size;
         cfg.pkt_count  = pkt_count_t'(count);
         cfg.port       = 3'd5;
         cfg.seed       = first_seq;
         exp_total      = count * $countones(en);
         exp_bad        = (flip >= 0) ? 1 : 0;
         flip_frame     = flip;
         start          = 1'b1;
         started        = 1'b1;
         @(negedge clk);
         start = 1'b0;
         wait_finished();
         @(negedge clk);
      end
   endtask

   initial begin
      start = 1'b0;
      cfg   = '0;
      wait_reset_done();
      // Idle outputs are watched for a while first
      repeat (10) @(negedge clk);
      run_test(5'b01111, 11'd64, 2, 32'h0000_0100, -1);
      run_test(PAT_RANDOM, 11'd64, 3, 32'h1234_5678, -1);
      run_test(5'b10001, 11'd60, 1, 32'h0000_1000, -1);
      run_test(5'b10001, 11'd61, 1, 32'h0000_2000, -1);
      run_test(5'b10001, 11'd62, 1, 32'h0000_3000, -1);
      run_test(5'b10001, 11'd63, 1, 32'h0000_4000, -1);
      run_test(PAT_RANDOM, 11'd2047, 1, 32'hdead_beef, -1);
      run_test(5'b11111, 11'd64, 2, 32'h0000_0042, 3);
      repeat (5) @(negedge clk);
      $display("Checks done: %0d value errors, %0d timeouts", value_errors, timeouts);
      if (value_errors == 0 && timeouts == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// File: dv/tb_clk_gen.sv
/* Free-running 8 ns clock. Synchronous reset is held for 3 rising edges */
`timescale 1ns/10ps

module tb_clk_gen (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Reset drops on a falling edge, like all other stimulus
   initial begin
      reset = 1'b1;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

// File: flist.f
logic/selftest_pkt_pkg.sv
logic/selftest_ctl_pkg.sv
logic/lfsr32.sv
logic/test_sequencer.sv
logic/phy_test_pktgen.sv
logic/phy_test_pktchk.sv
logic/phy_selftest.sv
dv/tb_clk_gen.sv
dv/phy_selftest_tb.sv

// File: logic/lfsr32.sv
/* 32-bit Galois LFSR. load wins over advance.
   An all-zero seed locks it up, so random frames need a nonzero sequence number */
`timescale 1ns/10ps

module lfsr32 (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   load,
   input  selftest_pkt_pkg::seq_t seed,
   input  logic                   advance,
   output selftest_pkt_pkg::seq_t value
);
   import selftest_pkt_pkg::*;

   always_ff @(posedge clk) begin
      if (reset) begin
         value <= seq_t'(1);
      end else if (load) begin
         value <= seed;
      end else if (advance) begin
         // Shift left, fold the outgoing bit back through the taps
         value <= {value[30:0], 1'b0} ^ (value[31] ? LFSR_TAPS : '0);
      end
   end

   // Stepping from zero means a zero seed got in
   assert property (@(posedge clk) disable iff (reset)
      (advance && !load) |-> (value != '0))
      else $error("lfsr32: advance from the all-zero lockup state");

endmodule

// File: logic/phy_selftest.sv
/* PHY self-test top. The frame loop from tx_word back to rx_word is outside.
   Hold cfg from start until finished */
`timescale 1ns/10ps

module phy_selftest (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            start,
   input  selftest_ctl_pkg::selftest_cfg_t cfg,
   input  logic                            tx_rd,
   output selftest_pkt_pkg::frame_word_t   tx_word,
   input  logic                            rx_valid,
   input  selftest_pkt_pkg::frame_word_t   rx_word,
   output logic                            running,
   output logic                            finished,
   output selftest_ctl_pkg::result_t       result
);
   import selftest_pkt_pkg::*;

   // Sequencer to generator
   pattern_t pattern;
   seq_t     seq_no;
   logic     gen_go;
   logic     gen_done;
   // Checker verdicts
   logic     pkt_good;
   logic     pkt_bad;

   test_sequencer i_test_sequencer (
      .clk      (clk),
      .reset    (reset),
      .start    (start),
      .cfg      (cfg),
      .gen_done (gen_done),
      .pkt_good (pkt_good),
      .pkt_bad  (pkt_bad),
      .pattern  (pattern),
      .seq_no   (seq_no),
      .gen_go   (gen_go),
      .running  (running),
      .finished (finished),
      .result   (result)
   );

   phy_test_pktgen i_phy_test_pktgen (
      .clk      (clk),
      .reset    (reset),
      .tx_rd    (tx_rd),
      .gen_go   (gen_go),
      .port     (cfg.port),
      .pattern  (pattern),
      .pkt_size (cfg.pkt_size),
      .seq_no   (seq_no),
      .tx_word  (tx_word),
      .busy     (),
      .gen_done (gen_done)
   );

   phy_test_pktchk i_phy_test_pktchk (
      .clk      (clk),
      .reset    (reset),
      .port     (cfg.port),
      .rx_valid (rx_valid),
      .rx_word  (rx_word),
      .pkt_good (pkt_good),
      .pkt_bad  (pkt_bad)
   );

endmodule

// File: logic/phy_test_pktchk.sv
/* Checks returned frames against the generator format for the given port.
   rx_word is sampled only while rx_valid is high; frames stay under 1024 words */
`timescale 1ns/10ps

module phy_test_pktchk (
   input  logic                          clk,
   input  logic                          reset,
   input  selftest_pkt_pkg::port_t       port,
   input  logic                          rx_valid,
   input  selftest_pkt_pkg::frame_word_t rx_word,
   output logic                          pkt_good,
   output logic                          pkt_bad
);
   import selftest_pkt_pkg::*;

   // Index of the incoming word
   word_cnt_t count;
   // Sticky mismatch for the current frame
   logic      bad;
   // Taken from word 3
   pattern_t  exp_pattern;
   word_cnt_t exp_last;
   ctrl_t     exp_ctrl;

   pkt_size_t rx_size;
   pattern_t  rx_pattern;
   seq_t      rand_data;
   logic      word_bad;
   logic      end_bad;
   logic      frame_bad;
   logic      lfsr_load;
   logic      lfsr_adv;

   assign rx_size    = rx_word.data[26:16];
   assign rx_pattern = rx_word.data[4:0];

   // ==============================
   // Per-word compare
   // ==============================
   always_comb begin
      case (count)
         W_DA_HI:       word_bad = rx_word.data != {ADDR_PREFIX, 8'h00};
         W_DA_LO_SA_HI: word_bad = rx_word.data != {8'h01, 5'd0, port, ADDR_PREFIX[23:8]};
         W_SA_LO:       word_bad = rx_word.data != {ADDR_PREFIX[7:0], 16'h0000, 5'd0, port};
         // Fixed f0 prefix, zero byte, legal size and pattern
         W_SIZE_PATTERN: begin
            word_bad = rx_word.data[31:27] != 5'b11110 || rx_word.data[15:5] != '0 ||
                       !$onehot(rx_pattern) || rx_size < MIN_PKT_SIZE;
         end
         // Any sequence number is fine
         W_SEQ:         word_bad = 1'b0;
         default:       word_bad = rx_word.data != pattern_word(exp_pattern, rand_data);
      endcase

      // Word count and end marker
      if (rx_word.last)
         end_bad = count < W_PAYLOAD || count != exp_last || rx_word.ctrl != exp_ctrl;
      else
         end_bad = rx_word.ctrl != '0;
   end

   assign frame_bad = bad || word_bad || end_bad;

   // ==============================
   // Frame tracking and verdict
   // ==============================
   always_ff @(posedge clk) begin
      if (reset) begin
         count    <= '0;
         bad      <= 1'b0;
         pkt_good <= 1'b0;
         pkt_bad  <= 1'b0;
      end else begin
         pkt_good <= rx_valid && rx_word.last && !frame_bad;
         pkt_bad  <= rx_valid && rx_word.last && frame_bad;
         if (rx_valid) begin
            if (rx_word.last) begin
               count <= '0;
               bad   <= 1'b0;
            end else begin
               count <= count + 1'b1;
               bad   <= frame_bad;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rx_valid && count == W_SIZE_PATTERN) begin
         exp_pattern <= rx_pattern;
         exp_last    <= last_word_idx(rx_size);
         exp_ctrl    <= end_ctrl(rx_size);
      end
   end

   // Same seeding as the sender, from the received sequence word
   assign lfsr_load = rx_valid && count == W_SEQ;
   assign lfsr_adv  = rx_valid && count >= W_PAYLOAD && exp_pattern == PAT_RANDOM;

   lfsr32 i_lfsr32 (
      .clk     (clk),
      .reset   (reset),
      .load    (lfsr_load),
      .seed    (rx_word.data),
      .advance (lfsr_adv),
      .value   (rand_data)
   );

endmodule

// File: logic/phy_test_pktgen.sv
/* Frame word source, one word per accepted tx_rd, registered out the next cycle.
   pattern and seq_no hold during a frame; pkt_size is at least MIN_PKT_SIZE.
   tx_rd is ignored when idle without gen_go and in the gen_done cycle */
`timescale 1ns/10ps

module phy_test_pktgen (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          tx_rd,
   input  logic                          gen_go,
   input  selftest_pkt_pkg::port_t       port,
   input  selftest_pkt_pkg::pattern_t    pattern,
   input  selftest_pkt_pkg::pkt_size_t   pkt_size,
   input  selftest_pkt_pkg::seq_t        seq_no,
   output selftest_pkt_pkg::frame_word_t tx_word,
   output logic                          busy,
   output logic                          gen_done
);
   import selftest_pkt_pkg::*;

   // Index of the word sent on the next read
   word_cnt_t count;
   logic      in_frame;
   // Size-derived values, caught on the first read
   word_cnt_t last_idx;
   ctrl_t     final_ctrl;

   logic      start_frame;
   logic      rd_frame;
   logic      last_word;
   logic      lfsr_load;
   logic      lfsr_adv;
   seq_t      rand_data;
   word_t     word_nxt;

   assign busy        = in_frame | gen_done;
   assign start_frame = tx_rd && gen_go && !busy;
   assign rd_frame    = tx_rd && in_frame;
   assign last_word   = count == last_idx;

   // ==============================
   // Word counter
   // ==============================
   always_ff @(posedge clk) begin
      // Data follows every accepted read, stalls keep the old word
      if (start_frame || rd_frame)
         tx_word.data <= word_nxt;
      if (start_frame) begin
         last_idx   <= last_word_idx(pkt_size);
         final_ctrl <= end_ctrl(pkt_size);
      end

      if (reset) begin
         in_frame     <= 1'b0;
         count        <= '0;
         gen_done     <= 1'b0;
         tx_word.ctrl <= '0;
         tx_word.last <= 1'b0;
      end else begin
         gen_done <= 1'b0;
         if (start_frame) begin
            // Word 0 goes out now
            in_frame     <= 1'b1;
            count        <= W_DA_LO_SA_HI;
            tx_word.ctrl <= '0;
            tx_word.last <= 1'b0;
         end else if (rd_frame) begin
            tx_word.ctrl <= last_word ? final_ctrl : '0;
            tx_word.last <= last_word;
            gen_done     <= last_word;
            in_frame     <= !last_word;
            count        <= last_word ? '0 : count + 1'b1;
         end
      end
   end

   // ==============================
   // Word content
   // ==============================
   always_comb begin
      case (count)
         W_DA_HI:        word_nxt = {ADDR_PREFIX, 8'h00};
         // DA low bytes 01:port, SA high bytes 00:ca
         W_DA_LO_SA_HI:  word_nxt = {8'h01, 5'd0, port, ADDR_PREFIX[23:8]};
         W_SA_LO:        word_nxt = {ADDR_PREFIX[7:0], 16'h0000, 5'd0, port};
         W_SIZE_PATTERN: word_nxt = {4'hf, 1'b0, pkt_size, 8'h00, 3'd0, pattern};
         W_SEQ:          word_nxt = seq_no;
         default:        word_nxt = pattern_word(pattern, rand_data);
      endcase
   end

   // Seeded as word 4 goes out, so word 5 repeats the sequence number
   assign lfsr_load = rd_frame && count == W_SEQ;
   assign lfsr_adv  = rd_frame && count >= W_PAYLOAD && pattern == PAT_RANDOM;

   lfsr32 i_lfsr32 (
      .clk     (clk),
      .reset   (reset),
      .load    (lfsr_load),
      .seed    (seq_no),
      .advance (lfsr_adv),
      .value   (rand_data)
   );

   // Sequencer must hand over exactly one pattern
   assert property (@(posedge clk) disable iff (reset)
      start_frame |-> $onehot(pattern))
      else $error("phy_test_pktgen: frame started without a one-hot pattern");

endmodule

// File: logic/selftest_ctl_pkg.sv
/* Control side of the self-test: sequencer states, run configuration and results.
   pkt_count times the number of enabled patterns must fit in 16 bits */
package selftest_ctl_pkg;

   // Sequencer FSM
   typedef enum logic [1:0] {
      IDLE,
      LAUNCH,
      SENDING,
      DRAIN
   } seq_state_t;

   typedef logic [15:0] pkt_count_t;

   // Run configuration, held by the host while running
   typedef struct packed {
      selftest_pkt_pkg::pattern_t  pattern_en;
      selftest_pkt_pkg::pkt_size_t pkt_size;
      // Frames per enabled pattern
      pkt_count_t                  pkt_count;
      selftest_pkt_pkg::port_t     port;
      // Sequence number of the first frame
      selftest_pkt_pkg::seq_t      seed;
   } selftest_cfg_t;

   // Run totals
   typedef struct packed {
      pkt_count_t sent;
      pkt_count_t good;
      pkt_count_t bad;
   } result_t;

endpackage

// File: logic/selftest_pkt_pkg.sv
/* Frame layout of the PHY self-test, shared by generator, checker and testbench.
   Header is words 0 to 4 and payload starts at word 5. Sizes run up to 2047 bytes */
package selftest_pkt_pkg;

   // ==============================
   // Field types
   // ==============================
   typedef logic [31:0] word_t;
   typedef logic [3:0]  ctrl_t;
   typedef logic [10:0] pkt_size_t;
   typedef logic [2:0]  port_t;
   typedef logic [31:0] seq_t;
   typedef logic [4:0]  pattern_t;
   // Word index in a frame, 2047 bytes needs 512 words
   typedef logic [9:0]  word_cnt_t;

   // One-hot pattern codes, low byte of word 3
   localparam pattern_t PAT_ALL_0  = 5'b00001;
   localparam pattern_t PAT_ALL_1  = 5'b00010;
   localparam pattern_t PAT_ALT_01 = 5'b00100;
   localparam pattern_t PAT_ALT_10 = 5'b01000;
   localparam pattern_t PAT_RANDOM = 5'b10000;

   // Word positions
   localparam word_cnt_t W_DA_HI        = 10'd0;
   localparam word_cnt_t W_DA_LO_SA_HI  = 10'd1;
   localparam word_cnt_t W_SA_LO        = 10'd2;
   localparam word_cnt_t W_SIZE_PATTERN = 10'd3;
   localparam word_cnt_t W_SEQ          = 10'd4;
   localparam word_cnt_t W_PAYLOAD      = 10'd5;

   // DA and SA both start with 00:ca:fe
   localparam logic [23:0] ADDR_PREFIX  = 24'h00_ca_fe;
   // Smallest size that still holds one payload word
   localparam pkt_size_t   MIN_PKT_SIZE = 11'd24;
   // Galois taps of x^32 + x^22 + x^2 + x + 1
   localparam seq_t        LFSR_TAPS    = 32'h0040_0007;

   // One word on the transmit or receive port
   typedef struct packed {
      word_t data;
      ctrl_t ctrl;
      logic  last;
   } frame_word_t;

   // ==============================
   // Size and payload rules
   // ==============================
   // Index of the last word, ceil(size/4) - 1
   function automatic word_cnt_t last_word_idx(pkt_size_t size);
      return word_cnt_t'(size[10:2]) + word_cnt_t'(|size[1:0]) - 10'd1;
   endfunction

   // Byte-end marker on the last word
   function automatic ctrl_t end_ctrl(pkt_size_t size);
      ctrl_t c;
      case (size[1:0])
         2'd0:    c = 4'b0001;
         2'd1:    c = 4'b1000;
         2'd2:    c = 4'b0100;
         default: c = 4'b0010;
      endcase
      return c;
   endfunction

   // Payload value, the LFSR word stands in for the random pattern
   function automatic word_t pattern_word(pattern_t pat, word_t rand_word);
      word_t w;
      case (pat)
         PAT_ALL_0:  w = 32'h0000_0000;
         PAT_ALL_1:  w = 32'hffff_ffff;
         PAT_ALT_01: w = 32'h5555_5555;
         PAT_ALT_10: w = 32'haaaa_aaaa;
         default:    w = rand_word;
      endcase
      return w;
   endfunction

endpackage

// File: logic/test_sequencer.sv
/* Runs pkt_count frames for each enabled pattern, lowest bit first.
   cfg must hold from start until finished. start is ignored while running */
`timescale 1ns/10ps

module test_sequencer (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            start,
   input  selftest_ctl_pkg::selftest_cfg_t cfg,
   input  logic                            gen_done,
   input  logic                            pkt_good,
   input  logic                            pkt_bad,
   output selftest_pkt_pkg::pattern_t      pattern,
   output selftest_pkt_pkg::seq_t          seq_no,
   output logic                            gen_go,
   output logic                            running,
   output logic                            finished,
   output selftest_ctl_pkg::result_t       result
);
   import selftest_pkt_pkg::*;
   import selftest_ctl_pkg::*;

   seq_state_t state;
   // Enabled patterns not yet run
   pattern_t   pat_left;
   pattern_t   next_pat;
   pkt_count_t frames_left;
   // Verdicts so far
   pkt_count_t done_cnt;

   // Lowest set bit of the remaining patterns
   assign next_pat = pat_left & (~pat_left + pattern_t'(1));
   assign done_cnt = result.good + result.bad;
   assign gen_go   = state == SENDING;
   assign running  = state != IDLE;

   // ==============================
   // Pattern walk and counters
   // ==============================
   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= IDLE;
         pat_left    <= '0;
         frames_left <= '0;
         pattern     <= '0;
         seq_no      <= '0;
         result      <= '0;
         finished    <= 1'b0;
      end else begin
         finished <= 1'b0;
         // Verdicts come back from the loop at any point of the run
         if (running && pkt_good)
            result.good <= result.good + 1'b1;
         if (running && pkt_bad)
            result.bad <= result.bad + 1'b1;

         case (state)
            IDLE: begin
               if (start) begin
                  pat_left <= cfg.pattern_en;
                  seq_no   <= cfg.seed;
                  result   <= '0;
                  state    <= LAUNCH;
               end
            end
            LAUNCH: begin
               pattern     <= next_pat;
               pat_left    <= pat_left & ~next_pat;
               frames_left <= cfg.pkt_count;
               // Nothing left to send, go straight to the wait
               state <= (pat_left == '0 || cfg.pkt_count == '0) ? DRAIN : SENDING;
            end
            SENDING: begin
               // Frame handed over, next one may start right away
               if (gen_done) begin
                  result.sent <= result.sent + 1'b1;
                  seq_no      <= seq_no + 1'b1;
                  frames_left <= frames_left - 1'b1;
                  if (frames_left == pkt_count_t'(1))
                     state <= (pat_left == '0) ? DRAIN : LAUNCH;
               end
            end
            DRAIN: begin
               // Frames still in the loop
               if (done_cnt == result.sent) begin
                  finished <= 1'b1;
                  state    <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Checker verdicts never outrun the frames sent
   assert property (@(posedge clk) disable iff (reset)
      (17'(result.good) + 17'(result.bad)) <= 17'(result.sent))
      else $error("test_sequencer: more verdicts than frames sent");

endmodule

// File: run.sh
#!/bin/sh
# Build and run the PHY self-test regression with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module phy_selftest_tb \
   -Mdir obj_dir -o phy_selftest_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/phy_selftest_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Regression failed" "$LOG"; then
   exit 1
fi
exit 0
